// ==== all.f ====
+incdir+bench
src/ctrlPkg.sv
src/instrDecoder.sv
src/ctrlSequencer.sv
src/ctrlWordRom.sv
src/controlUnit.sv
bench/controlUnitTb.sv

// ==== Bender.yml ====
package:
  name: control_unit

sources:
  - files:
      - src/ctrlPkg.sv
      - src/instrDecoder.sv
      - src/ctrlSequencer.sv
      - src/ctrlWordRom.sv
      - src/controlUnit.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/controlUnitTb.sv

// ==== bench/ctrlTests.svh ====
`ifndef CTRL_TESTS_SVH
`define CTRL_TESTS_SVH

// One instruction per row, stimulus then expected results
typedef struct {
    logic [5:0] opcode;
    logic [5:0] funct;
    logic       zero;
    logic       gt;
    // Cycles from one irWrite to the next
    int         period;
    int         regWrites;
    // pcWrite pulses outside fetch1
    int         extraPcWrites;
    // Fields below use -1 for not checked
    int         regDst;
    int         memToReg;
    int         aluOp;
    int         pcSrc;
    // Operation after the load, 0 when no shift
    int         shiftOp;
    logic       shiftSrc;
} testRow_t;

localparam int numTests = 23;

testRow_t tests[numTests];

function automatic testRow_t makeRow(
    input logic [5:0] op,
    input logic [5:0] fn,
    input logic       z,
    input logic       g,
    input int         per,
    input int         rw,
    input int         pw,
    input int         rd,
    input int         m2r,
    input int         alu,
    input int         pcs,
    input int         sh,
    input logic       src
);
    testRow_t r;
    r = '{op, fn, z, g, per, rw, pw, rd, m2r, alu, pcs, sh, src};
    return r;
endfunction

task automatic fillTable();
    //                  opcode   funct   z  g  per rw pw dst m2r alu pcs sh src
    tests[0]  = makeRow(opRType, fnAdd,  0, 0, 11, 1, 0,  1,  6,  1, -1, 0, 0);
    tests[1]  = makeRow(opRType, fnAnd,  0, 0, 11, 1, 0,  1,  6,  3, -1, 0, 0);
    tests[2]  = makeRow(opRType, fnSub,  0, 0, 11, 1, 0,  1,  6,  2, -1, 0, 0);
    tests[3]  = makeRow(opAddiu, fnSll,  0, 0, 11, 1, 0,  0,  6, -1, -1, 0, 0);
    tests[4]  = makeRow(opRType, fnMfhi, 0, 0,  9, 1, 0, -1,  2, -1, -1, 0, 0);
    tests[5]  = makeRow(opRType, fnMflo, 0, 0,  9, 1, 0, -1,  1, -1, -1, 0, 0);
    // Branches, taken then not taken
    tests[6]  = makeRow(opBeq,   fnSll,  1, 0, 10, 0, 1, -1, -1, -1, -1, 0, 0);
    tests[7]  = makeRow(opBeq,   fnSll,  0, 0,  9, 0, 0, -1, -1, -1, -1, 0, 0);
    tests[8]  = makeRow(opBne,   fnSll,  0, 0, 10, 0, 1, -1, -1, -1, -1, 0, 0);
    tests[9]  = makeRow(opBne,   fnSll,  1, 0,  9, 0, 0, -1, -1, -1, -1, 0, 0);
    tests[10] = makeRow(opBle,   fnSll,  0, 0, 10, 0, 1, -1, -1, -1, -1, 0, 0);
    tests[11] = makeRow(opBle,   fnSll,  0, 1,  9, 0, 0, -1, -1, -1, -1, 0, 0);
    tests[12] = makeRow(opBgt,   fnSll,  0, 1, 10, 0, 1, -1, -1, -1, -1, 0, 0);
    tests[13] = makeRow(opBgt,   fnSll,  0, 0,  9, 0, 0, -1, -1, -1, -1, 0, 0);
    // Jumps
    tests[14] = makeRow(opRType, fnJr,   0, 0, 10, 0, 1, -1, -1, -1,  2, 0, 0);
    tests[15] = makeRow(opRType, fnBrk,  0, 0, 10, 0, 1, -1, -1, -1,  2, 0, 0);
    // Shifts, immediate then variable
    tests[16] = makeRow(opRType, fnSll,  0, 0, 11, 1, 0,  1,  5, -1, -1, 2, 1);
    tests[17] = makeRow(opRType, fnSrl,  0, 0, 11, 1, 0,  1,  5, -1, -1, 3, 1);
    tests[18] = makeRow(opRType, fnSra,  0, 0, 11, 1, 0,  1,  5, -1, -1, 4, 1);
    tests[19] = makeRow(opRType, fnSllv, 0, 0, 11, 1, 0,  1,  5, -1, -1, 2, 0);
    tests[20] = makeRow(opRType, fnSrav, 0, 0, 11, 1, 0,  1,  5, -1, -1, 4, 0);
    // Unknown opcode, unknown funct
    tests[21] = makeRow(6'h3e,   fnSll,  0, 0,  8, 0, 0, -1, -1, -1, -1, 0, 0);
    tests[22] = makeRow(opRType, 6'h3f,  0, 0,  8, 0, 0, -1, -1, -1, -1, 0, 0);
endtask

`endif

// ==== bench/controlUnitTb.sv ====
module controlUnitTb import ctrlPkg::*; ();

    // Expected timing with default DUT parameters
    localparam int fetchWaitExp = 2;
    localparam int resetCycles  = 3;
    localparam int marginCycles = 20;

    logic                        clk;
    logic                        reset_in;
    opcode_e                     opcode;
    funct_e                      funct;
    logic                        zero;
    logic                        gt;
    aluOp_e                      aluOp;
    shiftOp_e                    shiftOp;
    logic                        regWrite;
    logic                        shiftSrcReg;
    logic [shiftAmtSelWidth-1:0] shiftAmtSel;
    logic [regDstWidth-1:0]      regDst;
    logic [memToRegWidth-1:0]    memToReg;
    logic [aluSrcAWidth-1:0]     aluSrcA;
    logic [aluSrcBWidth-1:0]     aluSrcB;
    logic [pcSrcWidth-1:0]       pcSrc;
    logic                        pcWrite;
    logic                        irWrite;
    logic                        aWrite;
    logic                        bWrite;
    logic                        aluOutWrite;
    logic                        resetOut;

    int errorCount;
    int passCount;
    int failCount;
    int cycleCount;
    int cycleLimit;

    `include "ctrlTests.svh"

    controlUnit i_controlUnit (
        .clk         (clk),
        .reset_in    (reset_in),
        .opcode      (opcode),
        .funct       (funct),
        .zero        (zero),
        .gt          (gt),
        .aluOp       (aluOp),
        .shiftOp     (shiftOp),
        .regWrite    (regWrite),
        .shiftSrcReg (shiftSrcReg),
        .shiftAmtSel (shiftAmtSel),
        .regDst      (regDst),
        .memToReg    (memToReg),
        .aluSrcA     (aluSrcA),
        .aluSrcB     (aluSrcB),
        .pcSrc       (pcSrc),
        .pcWrite     (pcWrite),
        .irWrite     (irWrite),
        .aWrite      (aWrite),
        .bWrite      (bWrite),
        .aluOutWrite (aluOutWrite),
        .resetOut    (resetOut)
    );

    // 20 unit clock period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Watchdog on total cycles
    initial begin
        cycleCount = 0;
        forever begin
            @(posedge clk);
            cycleCount++;
            if (cycleCount >= cycleLimit) begin
                $display("Timeout reached after %0d cycles", cycleCount);
                $display("Checks failed");
                $finish;
            end
        end
    end

    function automatic int tableCycles();
        int sum;
        sum = 0;
        for (int i = 0; i < numTests; i++) begin
            sum += tests[i].period;
        end
        return sum;
    endfunction

    task automatic reportMismatch(input int row, input string what, input int got,
                                  input int exp);
        errorCount++;
        $display("ERR %0t: row %0d %s expected %0d got %0d", $time, row, what, exp, got);
    endtask

    task automatic finishTest(input string name, input int startErrors);
        if (errorCount == startErrors) begin
            passCount++;
            $display("%s: pass", name);
        end else begin
            failCount++;
            $display("%s: FAIL", name);
        end
    endtask

    task automatic checkReset();
        int startErrors;
        int waitCycles;
        startErrors = errorCount;
        waitCycles  = 0;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        // Reset state, sampled before release
        if (resetOut !== 1'b1) reportMismatch(-1, "resetOut", resetOut, 1);
        if (regWrite !== 1'b1) reportMismatch(-1, "regWrite", regWrite, 1);
        if (regDst !== 2'd3) reportMismatch(-1, "regDst", regDst, 3);
        if (memToReg !== 3'd4) reportMismatch(-1, "memToReg", memToReg, 4);
        if ({pcWrite, irWrite, aWrite, bWrite, aluOutWrite} !== 5'b0) begin
            reportMismatch(-1, "other strobes",
                           {pcWrite, irWrite, aWrite, bWrite, aluOutWrite}, 0);
        end
        reset_in = 1'b0;
        @(negedge clk);
        // Fetch0 cycles until the first irWrite
        while (irWrite !== 1'b1) begin
            waitCycles++;
            if (resetOut !== 1'b0) reportMismatch(-1, "resetOut after reset", resetOut, 0);
            @(negedge clk);
        end
        if (waitCycles != fetchWaitExp + 1) begin
            reportMismatch(-1, "cycles to first irWrite", waitCycles, fetchWaitExp + 1);
        end
        finishTest("reset", startErrors);
    endtask

    task automatic runRow(input int idx);
        testRow_t t;
        int       startErrors;
        int       period;
        int       regWrites;
        int       pcWrites;
        int       seenDst;
        int       seenM2r;
        int       seenAlu;
        int       seenSrcA;
        int       seenPcSrc;
        int       seenAmtSel;
        int       shiftFirst;
        int       shiftSecond;
        logic     srcSeen;
        t           = tests[idx];
        startErrors = errorCount;
        period      = 0;
        regWrites   = 0;
        pcWrites    = 0;
        seenDst     = -1;
        seenM2r     = -1;
        seenAlu     = -1;
        seenSrcA    = -1;
        seenPcSrc   = -1;
        seenAmtSel  = -1;
        shiftFirst  = -1;
        shiftSecond = -1;
        srcSeen     = 1'b0;
        // Starts on the previous irWrite cycle
        do begin
            @(negedge clk);
            period++;
            if (regWrite === 1'b1) begin
                regWrites++;
                seenDst = regDst;
                seenM2r = memToReg;
            end
            // Fetch1 pcWrite is not an extra one
            if (pcWrite === 1'b1 && irWrite !== 1'b1) begin
                pcWrites++;
                seenPcSrc = pcSrc;
            end
            // Decode1 latch also writes A, skip it
            if (aluOutWrite === 1'b1 && aWrite !== 1'b1) begin
                seenAlu  = aluOp;
                seenSrcA = aluSrcA;
            end
            if (shiftOp != shNop) begin
                seenAmtSel = shiftAmtSel;
                if (shiftFirst < 0) shiftFirst = shiftOp;
                else if (shiftSecond < 0) shiftSecond = shiftOp;
            end
            if (shiftSrcReg === 1'b1) srcSeen = 1'b1;
            // New instruction from the cycle after irWrite
            if (period == 1) begin
                opcode = opcode_e'(t.opcode);
                funct  = funct_e'(t.funct);
                zero   = t.zero;
                gt     = t.gt;
            end
        end while (irWrite !== 1'b1);
        if (period != t.period) reportMismatch(idx, "irWrite period", period, t.period);
        if (regWrites != t.regWrites) reportMismatch(idx, "regWrite count", regWrites, t.regWrites);
        if (pcWrites != t.extraPcWrites) begin
            reportMismatch(idx, "extra pcWrite count", pcWrites, t.extraPcWrites);
        end
        if (t.regDst >= 0 && seenDst != t.regDst) reportMismatch(idx, "regDst", seenDst, t.regDst);
        if (t.memToReg >= 0 && seenM2r != t.memToReg) begin
            reportMismatch(idx, "memToReg", seenM2r, t.memToReg);
        end
        if (t.aluOp >= 0 && seenAlu != t.aluOp) reportMismatch(idx, "aluOp", seenAlu, t.aluOp);
        // Register ALU ops read A
        if (t.aluOp >= 0 && seenSrcA != 2) reportMismatch(idx, "aluSrcA", seenSrcA, 2);
        if (t.pcSrc >= 0 && seenPcSrc != t.pcSrc) reportMismatch(idx, "pcSrc", seenPcSrc, t.pcSrc);
        // Fetch1 adds 4 to PC
        if (aluSrcB !== 3'd1) reportMismatch(idx, "aluSrcB at irWrite", aluSrcB, 1);
        // Load first, then the operation
        if (shiftFirst != ((t.shiftOp == 0) ? -1 : 1)) begin
            reportMismatch(idx, "first shiftOp", shiftFirst, (t.shiftOp == 0) ? -1 : 1);
        end
        if (t.shiftOp != 0 && shiftSecond != t.shiftOp) begin
            reportMismatch(idx, "second shiftOp", shiftSecond, t.shiftOp);
        end
        // Shamt field for immediate forms, rs for variable
        if (t.shiftOp != 0 && seenAmtSel != (t.shiftSrc ? 2 : 0)) begin
            reportMismatch(idx, "shiftAmtSel", seenAmtSel, t.shiftSrc ? 2 : 0);
        end
        if (srcSeen != t.shiftSrc) reportMismatch(idx, "shiftSrcReg", srcSeen, t.shiftSrc);
        finishTest($sformatf("row %0d opcode %02h funct %02h period %0d", idx, t.opcode,
                             t.funct, period), startErrors);
    endtask

    initial begin
        errorCount = 0;
        passCount  = 0;
        failCount  = 0;
        reset_in   = 1'b1;
        opcode     = opRType;
        funct      = fnSll;
        zero       = 1'b0;
        gt         = 1'b0;
        fillTable();
        // Reset, fetch up to first irWrite, all rows, margin
        cycleLimit = resetCycles + fetchWaitExp + 3 + tableCycles() + marginCycles;
        checkReset();
        for (int i = 0; i < numTests; i++) begin
            runRow(i);
        end
        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 passCount + failCount, passCount, failCount, errorCount);
        if (errorCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== src/controlUnit.sv ====
module controlUnit import ctrlPkg::*; #(
    // Extra fetch0 cycles for memory
    parameter int fetchWait  = 2,
    // Extra decode1 cycles for register read
    parameter int decodeWait = 2
) (
    input  logic                        clk,
    input  logic                        reset_in,
    input  opcode_e                     opcode,
    input  funct_e                      funct,
    input  logic                        zero,
    input  logic                        gt,
    output aluOp_e                      aluOp,
    output shiftOp_e                    shiftOp,
    output logic                        regWrite,
    output logic                        shiftSrcReg,
    output logic [shiftAmtSelWidth-1:0] shiftAmtSel,
    output logic [regDstWidth-1:0]      regDst,
    output logic [memToRegWidth-1:0]    memToReg,
    output logic [aluSrcAWidth-1:0]     aluSrcA,
    output logic [aluSrcBWidth-1:0]     aluSrcB,
    output logic [pcSrcWidth-1:0]       pcSrc,
    output logic                        pcWrite,
    output logic                        irWrite,
    output logic                        aWrite,
    output logic                        bWrite,
    output logic                        aluOutWrite,
    output logic                        resetOut
);

    // Decoder results into the sequencer
    ctrlState_e dispatchState;
    ctrlState_e shiftState;
    logic       branchTaken;
    // Current FSM state into the ROM
    ctrlState_e state;

    instrDecoder i_instrDecoder (
        .opcode        (opcode),
        .funct         (funct),
        .zero          (zero),
        .gt            (gt),
        .dispatchState (dispatchState),
        .shiftState    (shiftState),
        .branchTaken   (branchTaken)
    );

    ctrlSequencer #(
        .fetchWait  (fetchWait),
        .decodeWait (decodeWait)
    ) i_ctrlSequencer (
        .clk           (clk),
        .reset_in      (reset_in),
        .dispatchState (dispatchState),
        .shiftState    (shiftState),
        .branchTaken   (branchTaken),
        .state         (state)
    );

    ctrlWordRom i_ctrlWordRom (
        .state       (state),
        .aluOp       (aluOp),
        .shiftOp     (shiftOp),
        .regWrite    (regWrite),
        .shiftSrcReg (shiftSrcReg),
        .shiftAmtSel (shiftAmtSel),
        .regDst      (regDst),
        .memToReg    (memToReg),
        .aluSrcA     (aluSrcA),
        .aluSrcB     (aluSrcB),
        .pcSrc       (pcSrc),
        .pcWrite     (pcWrite),
        .irWrite     (irWrite),
        .aWrite      (aWrite),
        .bWrite      (bWrite),
        .aluOutWrite (aluOutWrite),
        .resetOut    (resetOut)
    );

endmodule

// ==== src/ctrlWordRom.sv ====
module ctrlWordRom import ctrlPkg::*; (
    input  ctrlState_e                  state,
    output aluOp_e                      aluOp,
    output shiftOp_e                    shiftOp,
    output logic                        regWrite,
    output logic                        shiftSrcReg,
    output logic [shiftAmtSelWidth-1:0] shiftAmtSel,
    output logic [regDstWidth-1:0]      regDst,
    output logic [memToRegWidth-1:0]    memToReg,
    output logic [aluSrcAWidth-1:0]     aluSrcA,
    output logic [aluSrcBWidth-1:0]     aluSrcB,
    output logic [pcSrcWidth-1:0]       pcSrc,
    output logic                        pcWrite,
    output logic                        irWrite,
    output logic                        aWrite,
    output logic                        bWrite,
    output logic                        aluOutWrite,
    output logic                        resetOut
);

    always_comb begin
        // Everything idle unless the state sets it
        aluOp       = aluPass;
        shiftOp     = shNop;
        regWrite    = 1'b0;
        shiftSrcReg = 1'b0;
        shiftAmtSel = '0;
        regDst      = '0;
        memToReg    = '0;
        aluSrcA     = '0;
        aluSrcB     = '0;
        pcSrc       = '0;
        pcWrite     = 1'b0;
        irWrite     = 1'b0;
        aWrite      = 1'b0;
        bWrite      = 1'b0;
        aluOutWrite = 1'b0;
        resetOut    = 1'b0;
        case (state)
            // Clears the stack pointer register
            stReset: begin
                resetOut = 1'b1;
                regWrite = 1'b1;
                regDst   = 2'd3;
                memToReg = 3'd4;
            end
            // PC + 4 on the ALU while memory reads
            stFetch0, stFetch1: begin
                aluSrcB = 3'd1;
                aluOp   = aluAdd;
                pcSrc   = 3'd2;
                pcWrite = (state == stFetch1);
                irWrite = (state == stFetch1);
            end
            // Branch target into ALUout, operands into A and B
            stDecode0, stDecode1: begin
                aluSrcB     = 3'd3;
                aluOp       = aluAdd;
                aWrite      = (state == stDecode1);
                bWrite      = (state == stDecode1);
                aluOutWrite = (state == stDecode1);
            end
            // A op B, result latched in second cycle
            stAdd0, stAdd1, stAnd0, stAnd1, stSub0, stSub1: begin
                aluSrcA     = 2'd2;
                aluOp       = (state inside {stAnd0, stAnd1}) ? aluAnd :
                              (state inside {stSub0, stSub1}) ? aluSub : aluAdd;
                aluOutWrite = (state inside {stAdd1, stAnd1, stSub1});
            end
            // rd <= ALUout
            stAluWriteBack, stAddiuWriteBack: begin
                regWrite = 1'b1;
                regDst   = (state == stAluWriteBack) ? 2'd1 : 2'd0;
                memToReg = 3'd6;
            end
            // A + sign extended immediate
            stAddiu0, stAddiu1: begin
                aluSrcA     = 2'd2;
                aluSrcB     = 3'd3;
                aluOp       = aluAdd;
                aluOutWrite = (state == stAddiu1);
            end
            stMfhi, stMflo: begin
                regWrite = 1'b1;
                regDst   = 2'd1;
                memToReg = (state == stMfhi) ? 3'd2 : 3'd1;
            end
            // A passed through to PC mux
            stJr: begin
                aluSrcA = 2'd2;
                aluOp   = aluPass;
                pcSrc   = 3'd2;
            end
            stBrk: begin
                aluSrcB = 3'd1;
                aluOp   = aluSub;
                pcSrc   = 3'd2;
            end
            // Compare A and B, target from ALUout
            stBeqBne, stBleBgt: begin
                aluSrcA = 2'd2;
                aluOp   = (state == stBeqBne) ? aluSub : aluCompare;
                pcSrc   = 3'd4;
            end
            stPcUpdate: begin
                pcWrite = 1'b1;
                pcSrc   = 3'd2;
            end
            // Immediate forms take B and shamt
            stShiftImmLoad, stSll, stSrl, stSra: begin
                shiftSrcReg = 1'b1;
                shiftAmtSel = 2'd2;
                shiftOp     = (state == stSll) ? shLeft :
                              (state == stSrl) ? shRightLogical :
                              (state == stSra) ? shRightArith : shLoad;
            end
            // Variable forms take A and rs
            stShiftVarLoad, stSllv, stSrav: begin
                shiftOp = (state == stSllv) ? shLeft :
                          (state == stSrav) ? shRightArith : shLoad;
            end
            stShiftWriteBack: begin
                regWrite = 1'b1;
                regDst   = 2'd1;
                memToReg = 3'd5;
            end
            default: begin
            end
        endcase
    end

    // Checked each time the FSM leaves a state
    irPcTogether: assert property (@(state) irWrite |-> (pcWrite && !regWrite))
        else $error("irWrite without pcWrite");

    // Register file and PC never written in the same state
    noDualWrite: assert property (@(state) !(regWrite && pcWrite))
        else $error("regWrite and pcWrite both high");

endmodule

// ==== src/ctrlSequencer.sv ====
module ctrlSequencer import ctrlPkg::*; #(
    parameter int fetchWait  = 2,
    parameter int decodeWait = 2
) (
    input  logic       clk,
    input  logic       reset_in,
    input  ctrlState_e dispatchState,
    input  ctrlState_e shiftState,
    input  logic       branchTaken,
    output ctrlState_e state
);

    // Counter sized for the longer memory wait
    localparam int maxWait   = (fetchWait > decodeWait) ? fetchWait : decodeWait;
    localparam int cntWidth  = (maxWait > 0) ? $clog2(maxWait + 1) : 1;

    localparam logic [cntWidth-1:0] fetchLimit  = cntWidth'(fetchWait);
    localparam logic [cntWidth-1:0] decodeLimit = cntWidth'(decodeWait);

    logic [cntWidth-1:0] waitCnt;
    logic [cntWidth-1:0] nextCnt;
    ctrlState_e          nextState;

    always_ff @(posedge clk) begin
        if (reset_in) begin
            state   <= stReset;
            waitCnt <= '0;
        end else begin
            state   <= nextState;
            waitCnt <= nextCnt;
        end
    end

    always_comb begin
        // Counter restarts on every state entry
        nextCnt   = '0;
        nextState = stReset;
        case (state)
            stReset: nextState = stFetch0;
            // Hold fetch0 until memory data is ready
            stFetch0: begin
                if (waitCnt == fetchLimit) begin
                    nextState = stFetch1;
                end else begin
                    nextState = stFetch0;
                    nextCnt   = waitCnt + 1'b1;
                end
            end
            stFetch1:  nextState = stDecode0;
            stDecode0: nextState = stDecode1;
            // Register read wait, then dispatch
            stDecode1: begin
                if (waitCnt == decodeLimit) begin
                    nextState = dispatchState;
                end else begin
                    nextState = stDecode1;
                    nextCnt   = waitCnt + 1'b1;
                end
            end
            // Register ALU ops
            stAdd0: nextState = stAdd1;
            stAnd0: nextState = stAnd1;
            stSub0: nextState = stSub1;
            stAdd1,
            stAnd1,
            stSub1: nextState = stAluWriteBack;
            // Immediate add
            stAddiu0: nextState = stAddiu1;
            stAddiu1: nextState = stAddiuWriteBack;
            // Jumps always update PC
            stJr,
            stBrk: nextState = stPcUpdate;
            // Not taken skips the PC write
            stBeqBne,
            stBleBgt: nextState = branchTaken ? stPcUpdate : stFetch0;
            // Load state picks the operation
            stShiftImmLoad,
            stShiftVarLoad: nextState = shiftState;
            stSll,
            stSrl,
            stSra,
            stSllv,
            stSrav: nextState = stShiftWriteBack;
            // Single cycle finishers
            stAluWriteBack,
            stAddiuWriteBack,
            stShiftWriteBack,
            stMfhi,
            stMflo,
            stPcUpdate: nextState = stFetch0;
            default: nextState = stReset;
        endcase
    end

    // Counter only runs inside the two wait states
    waitCntLimit: assert property (@(posedge clk) disable iff (reset_in)
        (state == stFetch0)  ? (waitCnt <= fetchLimit) :
        (state == stDecode1) ? (waitCnt <= decodeLimit) :
        (waitCnt == '0))
        else $error("wait counter out of range in state %0d", state);

    // Decoder must only hand over legal encodings
    stateKnown: assert property (@(posedge clk) disable iff (reset_in)
        state inside {stReset, stFetch0, stFetch1, stDecode0, stDecode1,
                      stAdd0, stAdd1, stAnd0, stAnd1, stSub0, stSub1,
                      stAluWriteBack, stAddiu0, stAddiu1, stAddiuWriteBack,
                      stMfhi, stMflo, stJr, stBrk, stBeqBne, stBleBgt,
                      stPcUpdate, stShiftImmLoad, stSll, stSrl, stSra,
                      stShiftVarLoad, stSllv, stSrav, stShiftWriteBack})
        else $error("illegal state encoding %0d", state);

endmodule

// ==== src/instrDecoder.sv ====
module instrDecoder import ctrlPkg::*; (
    input  opcode_e    opcode,
    input  funct_e     funct,
    input  logic       zero,
    input  logic       gt,
    output ctrlState_e dispatchState,
    output ctrlState_e shiftState,
    output logic       branchTaken
);

    // Entry state after decode1
    always_comb begin
        case (opcode)
            opRType: begin
                case (funct)
                    fnAdd:  dispatchState = stAdd0;
                    fnAnd:  dispatchState = stAnd0;
                    fnSub:  dispatchState = stSub0;
                    fnMfhi: dispatchState = stMfhi;
                    fnMflo: dispatchState = stMflo;
                    fnJr:   dispatchState = stJr;
                    fnBrk:  dispatchState = stBrk;
                    // Shift amount from shamt field
                    fnSll,
                    fnSrl,
                    fnSra:  dispatchState = stShiftImmLoad;
                    // Shift amount from rs
                    fnSllv,
                    fnSrav: dispatchState = stShiftVarLoad;
                    // Unknown funct, straight back to fetch
                    default: dispatchState = stFetch0;
                endcase
            end
            opAddiu: dispatchState = stAddiu0;
            // Equality branches share one state
            opBeq,
            opBne:   dispatchState = stBeqBne;
            // Magnitude branches share one state
            opBle,
            opBgt:   dispatchState = stBleBgt;
            default: dispatchState = stFetch0;
        endcase
    end

    // Operation state after a shift load
    always_comb begin
        case (funct)
            fnSll:   shiftState = stSll;
            fnSrl:   shiftState = stSrl;
            fnSra:   shiftState = stSra;
            fnSllv:  shiftState = stSllv;
            fnSrav:  shiftState = stSrav;
            // Not reachable from a load state
            default: shiftState = stFetch0;
        endcase
    end

    // Branch condition from ALU flags
    always_comb begin
        case (opcode)
            opBeq:   branchTaken = zero;
            opBne:   branchTaken = ~zero;
            opBgt:   branchTaken = gt;
            opBle:   branchTaken = ~gt;
            default: branchTaken = 1'b0;
        endcase
    end

endmodule

// ==== src/ctrlPkg.sv ====
package ctrlPkg;

    // Mux selector widths
    localparam int regDstWidth      = 2;
    localparam int aluSrcAWidth     = 2;
    localparam int shiftAmtSelWidth = 2;
    localparam int memToRegWidth    = 3;
    localparam int aluSrcBWidth     = 3;
    localparam int pcSrcWidth       = 3;

    // Control FSM states, 7-bit encoding
    typedef enum logic [6:0] {
        stReset          = 7'd0,
        stFetch0         = 7'd1,
        stFetch1         = 7'd2,
        stDecode0        = 7'd3,
        stDecode1        = 7'd4,
        stAdd0           = 7'd5,
        stAdd1           = 7'd6,
        stAluWriteBack   = 7'd7,
        stAddiu0         = 7'd8,
        stAddiu1         = 7'd9,
        stAddiuWriteBack = 7'd10,
        stAnd0           = 7'd11,
        stAnd1           = 7'd12,
        stSub0           = 7'd13,
        stSub1           = 7'd14,
        stMfhi           = 7'd15,
        stMflo           = 7'd16,
        stJr             = 7'd17,
        stBrk            = 7'd18,
        stBeqBne         = 7'd19,
        stBleBgt         = 7'd20,
        stPcUpdate       = 7'd21,
        stShiftImmLoad   = 7'd22,
        stSll            = 7'd23,
        stSra            = 7'd24,
        stShiftVarLoad   = 7'd25,
        stSllv           = 7'd26,
        stSrav           = 7'd27,
        stShiftWriteBack = 7'd28,
        // SRL gets its own code, separate from SRA
        stSrl            = 7'd29
    } ctrlState_e;

    // Primary opcodes
    typedef enum logic [5:0] {
        opRType = 6'h00,
        opBeq   = 6'h04,
        opBne   = 6'h05,
        opBle   = 6'h06,
        opBgt   = 6'h07,
        opAddiu = 6'h09
    } opcode_e;

    // R-type function field
    typedef enum logic [5:0] {
        fnSll  = 6'h00,
        fnSrl  = 6'h02,
        fnSra  = 6'h03,
        fnSllv = 6'h04,
        fnSrav = 6'h07,
        fnJr   = 6'h08,
        fnBrk  = 6'h0d,
        fnMfhi = 6'h10,
        fnMflo = 6'h12,
        fnAdd  = 6'h20,
        fnSub  = 6'h22,
        fnAnd  = 6'h24
    } funct_e;

    // ALU command
    typedef enum logic [2:0] {
        aluPass    = 3'd0,
        aluAdd     = 3'd1,
        aluSub     = 3'd2,
        aluAnd     = 3'd3,
        aluCompare = 3'd7
    } aluOp_e;

    // Shift register command
    typedef enum logic [2:0] {
        shNop          = 3'd0,
        shLoad         = 3'd1,
        shLeft         = 3'd2,
        shRightLogical = 3'd3,
        shRightArith   = 3'd4
    } shiftOp_e;

endpackage
